/* hw/dispatcher.sv */
/*
 * Tomasulo dispatcher
 * Checks hazards and resources, picks a reservation-station lane,
 * resolves operands with CDB bypass and registers the dispatch and
 * the in-order retire output
 */
`timescale 1ns/1ps

module dispatcher (
  input  logic                    clk,
  input  logic                    rst,
  input  tomasulo_pkg::cdb_t      cdb_r,
  input  tomasulo_pkg::inst_t     inst,
  input  logic                    inst_vld,
  input  tomasulo_pkg::lane_vec_t iss_vld_r,
  output logic                    inst_adv,
  output tomasulo_pkg::dispatch_t dis_r,
  output tomasulo_pkg::lane_vec_t dis_vld_r,
  output logic                    out_vld_r,
  output tomasulo_pkg::reg_t      out_wa_r,
  output tomasulo_pkg::word_t     out_wdata_r
);
  import tomasulo_pkg::*;

  tag_t        alloc_tag;
  logic        tag_full;
  robid_t      alloc_robid;
  logic        rob_full;
  word_t [1:0] rd_value;
  logic  [1:0] rd_busy;
  tag_t  [1:0] rd_tag;
  logic        dst_busy;
  lane_vec_t   navail;
  lane_vec_t   lane_ok;
  lane_vec_t   dis_vld_w;
  dispatch_t   dis_w;
  logic        retire_vld;
  reg_t        retire_wa;
  word_t       retire_data;

  // Lanes of the opcode class that still hold a credit
  assign lane_ok  = class_lanes(inst.op) & ~navail;

  // WAW stall on a busy destination, plus tag, ROB and credit stalls
  assign inst_adv = inst_vld & ~tag_full & ~rob_full & ~dst_busy & (|lane_ok);

  // Lowest eligible lane wins
  assign dis_vld_w = inst_adv ? (lane_ok & (~lane_ok + lane_vec_t'(1))) : '0;

  always_comb begin
    dis_w        = '0;
    dis_w.opcode = inst.op;
    dis_w.tag    = alloc_tag;
    dis_w.robid  = alloc_robid;
    dis_w.imm    = inst.imm;
    dis_w.wa     = inst.wa;
    // Immediate forms leave both operands zero and ready
    if (!has_imm(inst.op)) begin
      for (int i = 0; i < 2; i++) begin
        if (rd_busy[i] && cdb_r.vld && cdb_r.wa == inst.ra[i] && cdb_r.tag == rd_tag[i]) begin
          // Producer broadcasts this cycle, take its result directly
          dis_w.oprand[i].data = cdb_r.wdata;
        end else if (rd_busy[i]) begin
          dis_w.oprand[i].busy = 1'b1;
          dis_w.oprand[i].data = word_t'(rd_tag[i]);
        end else begin
          dis_w.oprand[i].data = rd_value[i];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dis_vld_r <= '0;
      out_vld_r <= 1'b0;
    end else begin
      dis_vld_r <= dis_vld_w;
      out_vld_r <= retire_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_adv)
      dis_r <= dis_w;
    if (retire_vld) begin
      out_wa_r    <= retire_wa;
      out_wdata_r <= retire_data;
    end
  end

  tag_free_list u_tag_free_list (
    .clk       (clk),
    .rst       (rst),
    .alloc     (inst_adv),
    .free_vld  (cdb_r.vld),
    .free_tag  (cdb_r.tag),
    .alloc_tag (alloc_tag),
    .full_r    (tag_full)
  );

  reg_status u_reg_status (
    .clk      (clk),
    .rst      (rst),
    .ra       (inst.ra),
    .wr_en    (inst_adv),
    .wr_reg   (inst.wa),
    .wr_tag   (alloc_tag),
    .cdb_r    (cdb_r),
    .rd_value (rd_value),
    .rd_busy  (rd_busy),
    .rd_tag   (rd_tag),
    .dst_busy (dst_busy)
  );

  rs_credit u_rs_credit (
    .clk      (clk),
    .rst      (rst),
    .take     (dis_vld_w),
    .give     (iss_vld_r),
    .navail_r (navail)
  );

  reorder_buffer u_reorder_buffer (
    .clk         (clk),
    .rst         (rst),
    .alloc       (inst_adv),
    .alloc_wa    (inst.wa),
    .cmpl_vld    (cdb_r.vld),
    .cmpl_id     (cdb_r.robid),
    .cmpl_data   (cdb_r.wdata),
    .alloc_id    (alloc_robid),
    .full_r      (rob_full),
    .retire_vld  (retire_vld),
    .retire_wa   (retire_wa),
    .retire_data (retire_data)
  );

  // At most one lane receives an instruction per cycle
  a_dis_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(dis_vld_r))
    else $error("dispatch to more than one lane");

endmodule

/* hw/reg_status.sv */
/*
 * Register status table
 * Holds value, busy bit and producer tag for each architectural
 * register; two source read ports and a destination busy lookup
 */
`timescale 1ns/1ps

module reg_status (
  input  logic                     clk,
  input  logic                     rst,
  input  tomasulo_pkg::reg_t [1:0] ra,
  input  logic                     wr_en,
  input  tomasulo_pkg::reg_t       wr_reg,
  input  tomasulo_pkg::tag_t       wr_tag,
  input  tomasulo_pkg::cdb_t       cdb_r,
  output tomasulo_pkg::word_t [1:0] rd_value,
  output logic [1:0]               rd_busy,
  output tomasulo_pkg::tag_t [1:0] rd_tag,
  output logic                     dst_busy
);
  import tomasulo_pkg::*;

  word_t            value_r [REG_N];
  tag_t             tag_r   [REG_N];
  logic [REG_N-1:0] busy_r;
  logic             cdb_hit;

  // Only the current producer may retire the busy state
  assign cdb_hit = cdb_r.vld && busy_r[cdb_r.wa] && (tag_r[cdb_r.wa] == cdb_r.tag);

  // Source lookups
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      rd_value[i] = value_r[ra[i]];
      rd_busy[i]  = busy_r[ra[i]];
      rd_tag[i]   = tag_r[ra[i]];
    end
  end

  assign dst_busy = busy_r[wr_reg];

  // New producer is written last so it wins over a CDB clear
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_r <= '0;
    end else begin
      if (cdb_hit)
        busy_r[cdb_r.wa] <= 1'b0;
      if (wr_en)
        busy_r[wr_reg] <= 1'b1;
    end
  end

  // Architectural registers start at zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < REG_N; i++)
        value_r[i] <= '0;
    end else if (cdb_hit) begin
      value_r[cdb_r.wa] <= cdb_r.wdata;
    end
  end

  // Tag only matters while the busy bit is set
  always_ff @(posedge clk) begin
    if (wr_en)
      tag_r[wr_reg] <= wr_tag;
  end

endmodule

/* hw/reorder_buffer.sv */
/*
 * Reorder buffer
 * Circular buffer of destination and result pairs; entries complete
 * out of order from the CDB and retire in program order from the head
 */
`timescale 1ns/1ps

module reorder_buffer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 alloc,
  input  tomasulo_pkg::reg_t   alloc_wa,
  input  logic                 cmpl_vld,
  input  tomasulo_pkg::robid_t cmpl_id,
  input  tomasulo_pkg::word_t  cmpl_data,
  output tomasulo_pkg::robid_t alloc_id,
  output logic                 full_r,
  output logic                 retire_vld,
  output tomasulo_pkg::reg_t   retire_wa,
  output tomasulo_pkg::word_t  retire_data
);
  import tomasulo_pkg::*;

  robid_t           head_r;
  robid_t           tail_r;
  logic [ROB_W:0]   count_r;
  logic [ROB_W:0]   count_w;
  logic [ROB_N-1:0] done_r;
  reg_t             wa_mem   [ROB_N];
  word_t            data_mem [ROB_N];
  robid_t           cmpl_off;

  assign alloc_id    = tail_r;

  // Head retires as soon as its result is in; out never stalls
  assign retire_vld  = done_r[head_r];
  assign retire_wa   = wa_mem[head_r];
  assign retire_data = data_mem[head_r];

  // Distance of the completing entry from the head
  assign cmpl_off = cmpl_id - head_r;

  always_comb begin
    case ({alloc, retire_vld})
      2'b10:   count_w = count_r + 1'b1;
      2'b01:   count_w = count_r - 1'b1;
      default: count_w = count_r;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head_r  <= '0;
      tail_r  <= '0;
      count_r <= '0;
      full_r  <= 1'b0;
      done_r  <= '0;
    end else begin
      if (alloc)
        tail_r <= tail_r + 1'b1;
      if (retire_vld) begin
        head_r         <= head_r + 1'b1;
        done_r[head_r] <= 1'b0;
      end
      if (cmpl_vld)
        done_r[cmpl_id] <= 1'b1;
      count_r <= count_w;
      full_r  <= (count_w == (ROB_W + 1)'(ROB_N));
    end
  end

  always_ff @(posedge clk) begin
    if (alloc)
      wa_mem[tail_r] <= alloc_wa;
    if (cmpl_vld)
      data_mem[cmpl_id] <= cmpl_data;
  end

  // Completion must land inside the live window and only once
  a_cmpl_live: assert property (@(posedge clk) disable iff (rst)
    cmpl_vld |-> ({1'b0, cmpl_off} < count_r) && !done_r[cmpl_id])
    else $error("completion of unallocated ROB entry");

endmodule

/* hw/rs_credit.sv */
/*
 * Reservation-station credits
 * One counter per lane, spent on dispatch and returned on issue,
 * with a registered no-credit flag per lane
 */
`timescale 1ns/1ps

module rs_credit (
  input  logic                    clk,
  input  logic                    rst,
  input  tomasulo_pkg::lane_vec_t take,
  input  tomasulo_pkg::lane_vec_t give,
  output tomasulo_pkg::lane_vec_t navail_r
);
  import tomasulo_pkg::*;

  crdt_t     crdt_r [LANE_N];
  crdt_t     crdt_w [LANE_N];
  lane_vec_t empty;
  lane_vec_t at_max;

  always_comb begin
    for (int i = 0; i < LANE_N; i++) begin
      case ({take[i], give[i]})
        2'b10:   crdt_w[i] = crdt_r[i] - 1'b1;
        2'b01:   crdt_w[i] = crdt_r[i] + 1'b1;
        default: crdt_w[i] = crdt_r[i];
      endcase
      empty[i]  = (crdt_r[i] == '0);
      at_max[i] = (crdt_r[i] == lane_crdt(i));
    end
  end

  // Flag from the next count so a return shows one cycle later
  always_ff @(posedge clk) begin
    for (int i = 0; i < LANE_N; i++) begin
      if (rst) begin
        crdt_r[i]   <= lane_crdt(i);
        navail_r[i] <= 1'b0;
      end else begin
        crdt_r[i]   <= crdt_w[i];
        navail_r[i] <= (crdt_w[i] == '0);
      end
    end
  end

  a_no_take_empty: assert property (@(posedge clk) disable iff (rst) (take & empty) == '0)
    else $error("dispatch to lane without credit");

  a_no_give_full: assert property (@(posedge clk) disable iff (rst) (give & at_max) == '0)
    else $error("issue from lane holding no entry");

endmodule

/* hw/tag_free_list.sv */
/*
 * Tag free list
 * Tracks the in-flight tags, hands out the lowest free one and
 * releases a tag when its result appears on the CDB
 */
`timescale 1ns/1ps

module tag_free_list (
  input  logic               clk,
  input  logic               rst,
  input  logic               alloc,
  input  logic               free_vld,
  input  tomasulo_pkg::tag_t free_tag,
  output tomasulo_pkg::tag_t alloc_tag,
  output logic               full_r
);
  import tomasulo_pkg::*;

  logic [TAG_N-1:0] used_r;
  logic [TAG_N-1:0] used_w;

  // Scan downward so the lowest free tag is the last one kept
  always_comb begin
    alloc_tag = '0;
    for (int i = TAG_N - 1; i >= 0; i--)
      if (!used_r[i])
        alloc_tag = tag_t'(i);
  end

  always_comb begin
    used_w = used_r;
    if (free_vld)
      used_w[free_tag] = 1'b0;
    if (alloc)
      used_w[alloc_tag] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      used_r <= '0;
      full_r <= 1'b0;
    end else begin
      used_r <= used_w;
      full_r <= &used_w;
    end
  end

  // Dispatcher must stall while every tag is in flight
  a_no_alloc_full: assert property (@(posedge clk) disable iff (rst) alloc |-> !full_r)
    else $error("tag allocated while pool full");

endmodule

/* hw/tomasulo_pkg.sv */
/*
 * Tomasulo dispatch stage shared definitions
 * Widths, counts, opcode classes, the lane map and the structs passed
 * between the dispatcher, its state blocks and the execution side
 */
package tomasulo_pkg;

  localparam int WORD_W     = 32;
  localparam int REG_N      = 32;
  localparam int REG_W      = 5;
  localparam int TAG_N      = 8;
  localparam int TAG_W      = 3;
  localparam int ROB_N      = 8;
  localparam int ROB_W      = 3;
  localparam int LANE_N     = 5;
  localparam int ARITH_RS_N = 2;
  localparam int LOGIC_RS_N = 2;
  localparam int MPY_RS_N   = 1;
  localparam int CRDT_W     = 2;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [REG_W-1:0]  reg_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [ROB_W-1:0]  robid_t;
  typedef logic [CRDT_W-1:0] crdt_t;
  typedef logic [LANE_N-1:0] lane_vec_t;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_ADDI,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ANDI,
    OP_MUL
  } opcode_t;

  // Lane map: 0..1 arithmetic, 2..3 logic, 4 multiply
  localparam lane_vec_t ARITH_LANES = lane_vec_t'(5'b00011);
  localparam lane_vec_t LOGIC_LANES = lane_vec_t'(5'b01100);
  localparam lane_vec_t MPY_LANES   = lane_vec_t'(5'b10000);

  // Busy operands carry the producer tag in the low bits of data
  typedef struct packed {
    logic  busy;
    word_t data;
  } oprand_t;

  typedef struct packed {
    opcode_t    op;
    reg_t       wa;
    reg_t [1:0] ra;
    word_t      imm;
  } inst_t;

  typedef struct packed {
    logic   vld;
    reg_t   wa;
    tag_t   tag;
    robid_t robid;
    word_t  wdata;
  } cdb_t;

  typedef struct packed {
    opcode_t       opcode;
    tag_t          tag;
    robid_t        robid;
    oprand_t [1:0] oprand;
    word_t         imm;
    reg_t          wa;
  } dispatch_t;

  function automatic logic is_arith(opcode_t op);
    return op inside {OP_ADD, OP_SUB, OP_ADDI};
  endfunction

  function automatic logic is_logic(opcode_t op);
    return op inside {OP_AND, OP_OR, OP_XOR, OP_ANDI};
  endfunction

  function automatic logic is_mpy(opcode_t op);
    return op == OP_MUL;
  endfunction

  // Immediate forms read no source registers
  function automatic logic has_imm(opcode_t op);
    return op inside {OP_ADDI, OP_ANDI};
  endfunction

  // Lanes able to take an opcode of this class
  function automatic lane_vec_t class_lanes(opcode_t op);
    if (is_arith(op)) return ARITH_LANES;
    if (is_logic(op)) return LOGIC_LANES;
    if (is_mpy(op)) return MPY_LANES;
    return '0;
  endfunction

  // Full credit count of each lane
  function automatic crdt_t lane_crdt(int lane);
    if (ARITH_LANES[lane]) return crdt_t'(ARITH_RS_N);
    if (LOGIC_LANES[lane]) return crdt_t'(LOGIC_RS_N);
    return crdt_t'(MPY_RS_N);
  endfunction

endpackage

/* run.sh */
#!/bin/sh
# Build and run the dispatcher testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module dispatcher_tb \
  -o dispatcher_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/dispatcher_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" sim.log; then
  exit 1
fi
exit 0

/* src.f */
hw/tomasulo_pkg.sv
hw/tag_free_list.sv
hw/reg_status.sv
hw/rs_credit.sv
hw/reorder_buffer.sv
hw/dispatcher.sv
verif/dispatcher_tb.sv

/* verif/dispatcher_tb.sv */
/*
 * Dispatcher testbench
 * Models the execution units behind the reservation-station lanes,
 * replays the program in order and checks dispatch, stalls and retire
 */
`timescale 1ns/1ps

module dispatcher_tb;
  import tomasulo_pkg::*;

  // Directed sections advance 15 instructions ahead of the random program
  localparam int RAND_N = 300;
  localparam int INST_N = RAND_N + 15;
  localparam int LIMIT  = 40 * INST_N + 200;

  typedef struct packed {
    reg_t  wa;
    word_t v;
  } exp_t;

  logic      clk;
  logic      rst;
  cdb_t      cdb_r;
  inst_t     inst;
  logic      inst_vld;
  lane_vec_t iss_vld_r;
  logic      inst_adv;
  dispatch_t dis_r;
  lane_vec_t dis_vld_r;
  logic      out_vld_r;
  reg_t      out_wa_r;
  word_t     out_wdata_r;

  integer    seed = 13685;
  int        errors = 0;
  int        cyc = 0;
  int        n_adv = 0;
  int        n_byp = 0;
  dispatch_t lq [LANE_N][$];
  cdb_t      pend_q [$];
  exp_t      exp_q [$];
  word_t     arch [REG_N];
  logic      busy_t [REG_N];
  tag_t      tag_m [REG_N];
  int        crd [LANE_N];
  inst_t     cur_inst;
  logic      cur_vld;
  logic      adv_s;
  logic      rnd;
  lane_vec_t iss_en;
  logic      cdb_en;
  lane_vec_t exp_lane;
  logic [1:0] byp_m;
  word_t     byp_data;
  reg_t      next_wa;

  dispatcher dut (
    .clk         (clk),
    .rst         (rst),
    .cdb_r       (cdb_r),
    .inst        (inst),
    .inst_vld    (inst_vld),
    .iss_vld_r   (iss_vld_r),
    .inst_adv    (inst_adv),
    .dis_r       (dis_r),
    .dis_vld_r   (dis_vld_r),
    .out_vld_r   (out_vld_r),
    .out_wa_r    (out_wa_r),
    .out_wdata_r (out_wdata_r)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Watchdog ends a hung run
  initial begin
    while (cyc < LIMIT) begin
      @(posedge clk);
      cyc++;
    end
    $display("Timeout: run exceeded %0d cycles", LIMIT);
    $display(">>> FAIL");
    $finish;
  end

  // Expected result of one instruction
  function automatic word_t calc(opcode_t op, word_t a, word_t b, word_t imm);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_ADDI: return a + imm;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_ANDI: return a & imm;
      OP_MUL:  return a * b;
      default: return '0;
    endcase
  endfunction

  function automatic logic imm_op(opcode_t op);
    return (op == OP_ADDI) || (op == OP_ANDI);
  endfunction

  // Lanes serving each opcode class
  function automatic lane_vec_t lanes_of(opcode_t op);
    case (op)
      OP_ADD, OP_SUB, OP_ADDI:       return lane_vec_t'(5'b00011);
      OP_AND, OP_OR, OP_XOR, OP_ANDI: return lane_vec_t'(5'b01100);
      default:                        return lane_vec_t'(5'b10000);
    endcase
  endfunction

  task automatic check_word(string name, word_t exp, word_t act);
    if (exp !== act) begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_reg(string name, reg_t exp, reg_t act);
    if (exp !== act) begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_lane(string name, lane_vec_t exp, lane_vec_t act);
    if (exp !== act) begin
      $display("Error %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("Error %s: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  // One clock cycle of execution model, stimulus and checks
  task automatic cycle();
    dispatch_t d;
    cdb_t      c;
    exp_t      e;
    lane_vec_t give;
    lane_vec_t avail;
    lane_vec_t cls;
    int        idx;
    int        pick;
    word_t     a;
    word_t     b;
    @(negedge clk);
    // Last cycle's CDB clears its producer in the busy model
    if (cdb_r.vld && busy_t[cdb_r.wa] && tag_m[cdb_r.wa] == cdb_r.tag)
      busy_t[cdb_r.wa] = 1'b0;
    // Capture the dispatch into its lane
    check_lane("dispatch lane", exp_lane, dis_vld_r);
    if (dis_vld_r != '0) begin
      for (int k = 0; k < 2; k++) begin
        if (byp_m[k]) begin
          n_byp++;
          check_bit("bypass busy", 1'b0, dis_r.oprand[k].busy);
          check_word("bypass data", byp_data, dis_r.oprand[k].data);
        end
      end
      busy_t[dis_r.wa] = 1'b1;
      tag_m[dis_r.wa]  = dis_r.tag;
      for (int l = 0; l < LANE_N; l++)
        if (dis_vld_r[l])
          lq[l].push_back(dis_r);
    end
    byp_m = '0;
    // In-order retire against the program model
    if (out_vld_r) begin
      if (exp_q.size() == 0) begin
        $display("Retire seen with no instruction outstanding");
        errors++;
      end else begin
        e = exp_q.pop_front();
        check_reg("retire wa", e.wa, out_wa_r);
        check_word("retire data", e.v, out_wdata_r);
      end
    end
    // CDB picks any finished result, out of order when random
    c = '0;
    if (cdb_en && pend_q.size() > 0 && (!rnd || ($random(seed) & 3) != 0)) begin
      idx = rnd ? int'($unsigned($random(seed)) % pend_q.size()) : 0;
      c   = pend_q[idx];
      pend_q.delete(idx);
      for (int l = 0; l < LANE_N; l++) begin
        for (int j = 0; j < lq[l].size(); j++) begin
          d = lq[l][j];
          for (int k = 0; k < 2; k++) begin
            if (d.oprand[k].busy && d.oprand[k].data[TAG_W-1:0] == c.tag) begin
              d.oprand[k].busy = 1'b0;
              d.oprand[k].data = c.wdata;
            end
          end
          lq[l][j] = d;
        end
      end
    end
    cdb_r = c;
    // Issue the oldest ready entry of each lane
    give = '0;
    for (int l = 0; l < LANE_N; l++) begin
      pick = -1;
      if (iss_en[l] && (!rnd || ($random(seed) & 1) != 0)) begin
        for (int j = lq[l].size() - 1; j >= 0; j--)
          if (!lq[l][j].oprand[0].busy && !lq[l][j].oprand[1].busy)
            pick = j;
      end
      if (pick >= 0) begin
        d = lq[l][pick];
        lq[l].delete(pick);
        c.vld   = 1'b1;
        c.wa    = d.wa;
        c.tag   = d.tag;
        c.robid = d.robid;
        c.wdata = calc(d.opcode, d.oprand[0].data, d.oprand[1].data, d.imm);
        pend_q.push_back(c);
        give[l] = 1'b1;
      end
    end
    iss_vld_r = give;
    inst      = cur_inst;
    inst_vld  = cur_vld;
    // Sample the advance well clear of the edges
    #2;
    adv_s = inst_adv;
    cls   = lanes_of(inst.op);
    avail = '0;
    for (int l = 0; l < LANE_N; l++)
      avail[l] = cls[l] && crd[l] > 0;
    if (inst_vld && busy_t[inst.wa])
      check_bit("waw stall", 1'b0, inst_adv);
    if (avail == '0)
      check_bit("credit stall", 1'b0, inst_adv);
    exp_lane = '0;
    if (adv_s) begin
      for (int l = LANE_N - 1; l >= 0; l--) begin
        if (avail[l]) begin
          exp_lane    = '0;
          exp_lane[l] = 1'b1;
        end
      end
      for (int l = 0; l < LANE_N; l++)
        if (exp_lane[l])
          crd[l]--;
      if (!imm_op(inst.op)) begin
        for (int k = 0; k < 2; k++)
          byp_m[k] = busy_t[inst.ra[k]] && cdb_r.vld && cdb_r.tag == tag_m[inst.ra[k]];
      end
      byp_data = cdb_r.wdata;
      // Program-order replay
      a = imm_op(inst.op) ? '0 : arch[inst.ra[0]];
      b = imm_op(inst.op) ? '0 : arch[inst.ra[1]];
      e.wa = inst.wa;
      e.v  = calc(inst.op, a, b, inst.imm);
      arch[inst.wa] = e.v;
      exp_q.push_back(e);
      n_adv++;
    end
    for (int l = 0; l < LANE_N; l++)
      if (give[l])
        crd[l]++;
  endtask

  // Directed instruction reading r0 with a fresh destination
  task automatic new_inst(opcode_t op);
    cur_inst.op  = op;
    cur_inst.ra  = '0;
    cur_inst.wa  = next_wa;
    cur_inst.imm = $random(seed);
    next_wa      = (next_wa == reg_t'(REG_N - 1)) ? reg_t'(1) : next_wa + 1'b1;
  endtask

  task automatic rand_inst();
    cur_inst.op    = opcode_t'(3'($random(seed)));
    cur_inst.wa    = reg_t'($random(seed) & 7);
    cur_inst.ra[0] = reg_t'($random(seed) & 7);
    cur_inst.ra[1] = reg_t'($random(seed) & 7);
    cur_inst.imm   = $random(seed);
  endtask

  task automatic drain();
    cur_vld = 1'b0;
    iss_en  = '1;
    cdb_en  = 1'b1;
    while (exp_q.size() > 0)
      cycle();
    repeat (3) cycle();
  endtask

  // Fill one class with issue withheld, then return a single credit
  task automatic fill_class(opcode_t op, int n_cyc, int exp_n, string name);
    int n0;
    n0 = n_adv;
    new_inst(op);
    cur_vld = 1'b1;
    repeat (n_cyc) begin
      cycle();
      if (adv_s)
        new_inst(op);
    end
    cur_vld = 1'b0;
    check_word(name, word_t'(exp_n), word_t'(n_adv - n0));
  endtask

  initial begin
    int n0;
    rst       = 1'b1;
    inst      = '0;
    inst_vld  = 1'b0;
    iss_vld_r = '0;
    cdb_r     = '0;
    cur_inst  = '0;
    cur_vld   = 1'b0;
    rnd       = 1'b0;
    iss_en    = '0;
    cdb_en    = 1'b0;
    exp_lane  = '0;
    byp_m     = '0;
    byp_data  = '0;
    next_wa   = reg_t'(1);
    for (int i = 0; i < REG_N; i++) begin
      arch[i]   = '0;
      busy_t[i] = 1'b0;
      tag_m[i]  = '0;
    end
    for (int l = 0; l < LANE_N; l++)
      crd[l] = (l == LANE_N - 1) ? MPY_RS_N : ((l < 2) ? ARITH_RS_N : LOGIC_RS_N);
    repeat (8) @(negedge clk);
    rst = 1'b0;

    // Clean outputs after reset and an immediate first advance
    check_bit("dis_vld after reset", 1'b0, |dis_vld_r);
    check_bit("out_vld after reset", 1'b0, out_vld_r);
    new_inst(OP_ADD);
    cur_vld = 1'b1;
    cycle();
    check_bit("first advance", 1'b1, adv_s);
    cur_vld = 1'b0;
    drain();

    // Credit exhaustion per class, then one returned credit
    iss_en = '0;
    cdb_en = 1'b0;
    fill_class(OP_MUL, 6, MPY_RS_N, "mul credits");
    fill_class(OP_ADD, 8, 2 * ARITH_RS_N, "arith credits");
    iss_en = lane_vec_t'(5'b00001);
    cycle();
    iss_en = '0;
    fill_class(OP_SUB, 6, 1, "arith after one issue");
    drain();

    // No results returned so tags and ROB entries run out
    iss_en = '1;
    cdb_en = 1'b0;
    fill_class(OP_XOR, 20, (TAG_N < ROB_N) ? TAG_N : ROB_N, "in-flight limit");
    drain();

    // Random program with out-of-order completion
    rnd = 1'b1;
    n0  = n_adv;
    rand_inst();
    while (n_adv - n0 < RAND_N) begin
      cur_vld = ($random(seed) & 3) != 0;
      cycle();
      if (adv_s)
        rand_inst();
    end
    drain();

    if (n_byp == 0) begin
      $display("No dispatch ever took an operand from the CDB bypass");
      errors++;
    end

    $display("Errors: %0d", errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule
